//--- hw/rv_core.sv
`timescale 1ns/10ps

module rv_core (
        input  logic               clk,
        input  logic               i_rst_n,
        input  rv_pkg::imem_load_t i_load,
        input  logic               i_start,
        output rv_pkg::wb_trace_t  o_wb,
        output logic               o_halt
);
        import rv_pkg::*;

        instr_t   if_instr;
        pc_t      if_pc;
        logic     if_valid;
        reg_id_t  id_rs1;
        reg_id_t  id_rs2;
        reg_id_t  id_rd;
        word_t    id_imm;
        ctrl_t    id_ctrl;
        logic     id_illegal;
        word_t    id_rs1_data;
        word_t    id_rs2_data;
        id_ex_t   id_ex;
        id_ex_t   id_ex_d;
        ex_mem_t  ex_mem;
        mem_wb_t  mem_wb;
        fwd_sel_e fwd_a;
        fwd_sel_e fwd_b;
        word_t    ex_alu_result;
        word_t    ex_store_data;
        logic     ex_redirect;
        pc_t      ex_target;
        word_t    dmem_addr;
        word_t    dmem_rdata;
        logic     load_use;
        logic     halt_q;

        //////////////////////////////
        // IF and ID
        //////////////////////////////

        rv_fetch u_fetch (
                .clk        (clk),
                .i_rst_n    (i_rst_n),
                .i_load     (i_load),
                .i_start    (i_start),
                .i_stall    (load_use),
                .i_redirect (ex_redirect),
                .i_target   (ex_target),
                .i_halt_seen(o_halt),
                .o_instr    (if_instr),
                .o_pc       (if_pc),
                .o_valid    (if_valid)
        );

        rv_decode u_decode (
                .i_instr  (if_instr),
                .o_rs1    (id_rs1),
                .o_rs2    (id_rs2),
                .o_rd     (id_rd),
                .o_imm    (id_imm),
                .o_ctrl   (id_ctrl),
                .o_illegal(id_illegal)
        );

        // WB port writes, ID ports read
        rv_regfile u_regfile (
                .clk      (clk),
                .i_rst_n  (i_rst_n),
                .i_we     (mem_wb.reg_write),
                .i_wr_id  (mem_wb.rd),
                .i_rd1_id (id_rs1),
                .i_rd2_id (id_rs2),
                .i_wr_data(mem_wb.result),
                .o_rd1    (id_rs1_data),
                .o_rd2    (id_rs2_data)
        );

        // Load in EX feeding the instruction in ID
        assign load_use = id_ex.ctrl.mem_to_reg && if_valid &&
                          (id_ex.rd == id_rs1 || id_ex.rd == id_rs2);

        // Bubble on stall, flush or empty slot
        always_comb begin
                id_ex_d = '0;
                if (if_valid && !ex_redirect && !load_use) begin
                        id_ex_d.pc       = if_pc;
                        id_ex_d.rs1      = id_rs1;
                        id_ex_d.rs2      = id_rs2;
                        id_ex_d.rd       = id_rd;
                        id_ex_d.rs1_data = id_rs1_data;
                        id_ex_d.rs2_data = id_rs2_data;
                        id_ex_d.imm      = id_imm;
                        id_ex_d.ctrl     = id_ctrl;
                        // Writes to x0 never retire
                        id_ex_d.ctrl.reg_write = id_ctrl.reg_write && (id_rd != '0);
                end
        end

        //////////////////////////////
        // EX with forwarding
        //////////////////////////////

        // MEM wins over WB, loads never forward from MEM
        function automatic fwd_sel_e fwd_pick(reg_id_t rs, ex_mem_t em, mem_wb_t mw);
                if (em.reg_write && !em.mem_to_reg && em.rd == rs) begin
                        return FWD_MEM;
                end
                if (mw.reg_write && mw.rd == rs) begin
                        return FWD_WB;
                end
                return FWD_NONE;
        endfunction

        assign fwd_a = fwd_pick(id_ex.rs1, ex_mem, mem_wb);
        assign fwd_b = fwd_pick(id_ex.rs2, ex_mem, mem_wb);

        rv_execute u_execute (
                .i_id_ex     (id_ex),
                .i_fwd_a     (fwd_a),
                .i_fwd_b     (fwd_b),
                .i_from_mem  (ex_mem.alu_result),
                .i_from_wb   (mem_wb.result),
                .o_alu_result(ex_alu_result),
                .o_store_data(ex_store_data),
                .o_redirect  (ex_redirect),
                .o_target    (ex_target)
        );

        //////////////////////////////
        // MEM and WB
        //////////////////////////////

        // Address held at zero when no access
        assign dmem_addr = (ex_mem.mem_write || ex_mem.mem_to_reg) ? ex_mem.alu_result : '0;

        rv_data_mem u_data_mem (
                .clk    (clk),
                .i_we   (ex_mem.mem_write),
                .i_addr (dmem_addr),
                .i_wdata(ex_mem.store_data),
                .o_rdata(dmem_rdata)
        );

        // Pipeline registers, emptied on start
        always_ff @(posedge clk) begin
                if (!i_rst_n || i_start) begin
                        id_ex  <= '0;
                        ex_mem <= '0;
                        mem_wb <= '0;
                end else begin
                        id_ex <= id_ex_d;
                        ex_mem <= '{alu_result: ex_alu_result, store_data: ex_store_data,
                                    rd: id_ex.rd, reg_write: id_ex.ctrl.reg_write,
                                    mem_write: id_ex.ctrl.mem_write,
                                    mem_to_reg: id_ex.ctrl.mem_to_reg,
                                    halt: id_ex.ctrl.halt};
                        // Writeback select between load data and ALU
                        mem_wb <= '{result: ex_mem.mem_to_reg ? dmem_rdata : ex_mem.alu_result,
                                    rd: ex_mem.rd, reg_write: ex_mem.reg_write,
                                    halt: ex_mem.halt};
                end
        end

        // Halt sticks until the next start
        always_ff @(posedge clk) begin
                if (!i_rst_n || i_start) begin
                        halt_q <= 1'b0;
                end else if (mem_wb.halt) begin
                        halt_q <= 1'b1;
                end
        end

        assign o_halt = halt_q || mem_wb.halt;
        assign o_wb   = '{valid: mem_wb.reg_write, rd: mem_wb.rd, data: mem_wb.result};

        a_legal_fetch: assert property (
                @(posedge clk) disable iff (!i_rst_n) if_valid |-> !id_illegal)
                else $error("unsupported instruction %h at pc %h", if_instr, if_pc);

        // Fetch stops at ECALL so nothing retires behind it
        a_quiet_after_halt: assert property (
                @(posedge clk) disable iff (!i_rst_n) o_halt |-> !o_wb.valid)
                else $error("retirement after halt");

endmodule

//--- hw/rv_data_mem.sv
`timescale 1ns/10ps

module rv_data_mem (
        input  logic          clk,
        input  logic          i_we,
        input  rv_pkg::word_t i_addr,
        input  rv_pkg::word_t i_wdata,
        output rv_pkg::word_t o_rdata
);
        import rv_pkg::*;

        word_t              ram [2**DMEM_AW];
        logic [DMEM_AW-1:0] word_addr;

        // Byte address to word index
        assign word_addr = i_addr[DMEM_AW+1:2];

        always_ff @(posedge clk) begin
                if (i_we) begin
                        ram[word_addr] <= i_wdata;
                end
        end

        assign o_rdata = ram[word_addr];

        // Word accesses only, the core parks the address at zero otherwise
        a_word_aligned: assert property (
                @(posedge clk) $isunknown(i_addr) || i_addr[1:0] == 2'b00)
                else $error("unaligned data access at %h", i_addr);

endmodule

//--- hw/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
        input  rv_pkg::instr_t  i_instr,
        output rv_pkg::reg_id_t o_rs1,
        output rv_pkg::reg_id_t o_rs2,
        output rv_pkg::reg_id_t o_rd,
        output rv_pkg::word_t   o_imm,
        output rv_pkg::ctrl_t   o_ctrl,
        output logic            o_illegal
);
        import rv_pkg::*;

        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;

        //////////////////////////////
        // Fields
        //////////////////////////////

        assign opcode = i_instr[6:0];
        assign funct3 = i_instr[14:12];
        assign funct7 = i_instr[31:25];
        assign o_rd   = i_instr[11:7];
        assign o_rs1  = i_instr[19:15];
        assign o_rs2  = i_instr[24:20];

        // Sign-extended immediates per format
        assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
        assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
        // B format keeps bit 0 at zero
        assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                        i_instr[30:25], i_instr[11:8], 1'b0};

        //////////////////////////////
        // Control
        //////////////////////////////

        always_comb begin
                o_ctrl    = '0;
                o_imm     = imm_i;
                o_illegal = 1'b0;
                case (opcode)
                OPC_RTYPE: begin
                        o_ctrl.reg_write = 1'b1;
                        case ({funct7, funct3})
                        {7'h00, 3'b000}: o_ctrl.alu_op = ALU_ADD;
                        {7'h20, 3'b000}: o_ctrl.alu_op = ALU_SUB;
                        {7'h00, 3'b111}: o_ctrl.alu_op = ALU_AND;
                        {7'h00, 3'b110}: o_ctrl.alu_op = ALU_OR;
                        {7'h00, 3'b100}: o_ctrl.alu_op = ALU_XOR;
                        {7'h00, 3'b010}: o_ctrl.alu_op = ALU_SLT;
                        default:         o_illegal = 1'b1;
                        endcase
                end
                OPC_ITYPE: begin
                        // ADDI only
                        o_ctrl.reg_write   = 1'b1;
                        o_ctrl.alu_src_imm = 1'b1;
                        o_illegal          = (funct3 != 3'b000);
                end
                OPC_LOAD: begin
                        // LW, address is rs1 plus imm
                        o_ctrl.reg_write   = 1'b1;
                        o_ctrl.mem_to_reg  = 1'b1;
                        o_ctrl.alu_src_imm = 1'b1;
                        o_illegal          = (funct3 != 3'b010);
                end
                OPC_STORE: begin
                        o_ctrl.mem_write   = 1'b1;
                        o_ctrl.alu_src_imm = 1'b1;
                        o_imm              = imm_s;
                        o_illegal          = (funct3 != 3'b010);
                end
                OPC_BRANCH: begin
                        // BEQ or BNE
                        o_ctrl.branch    = 1'b1;
                        o_ctrl.branch_ne = funct3[0];
                        o_imm            = imm_b;
                        o_illegal        = (funct3[2:1] != 2'b00);
                end
                OPC_SYSTEM: begin
                        // ECALL ends the program
                        o_ctrl.halt = 1'b1;
                        o_illegal   = (i_instr != 32'h0000_0073);
                end
                default: o_illegal = 1'b1;
                endcase
                // Unsupported encodings become a bubble
                if (o_illegal) begin
                        o_ctrl = '0;
                end
        end

endmodule

//--- hw/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
        input  rv_pkg::id_ex_t   i_id_ex,
        input  rv_pkg::fwd_sel_e i_fwd_a,
        input  rv_pkg::fwd_sel_e i_fwd_b,
        input  rv_pkg::word_t    i_from_mem,
        input  rv_pkg::word_t    i_from_wb,
        output rv_pkg::word_t    o_alu_result,
        output rv_pkg::word_t    o_store_data,
        output logic             o_redirect,
        output rv_pkg::pc_t      o_target
);
        import rv_pkg::*;

        word_t op_a;
        word_t op_b;
        word_t alu_b;
        logic  equal;

        // Forwarding mux, same for both operands
        function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val,
                                          word_t mem_val, word_t wb_val);
                case (sel)
                FWD_MEM: return mem_val;
                FWD_WB:  return wb_val;
                default: return reg_val;
                endcase
        endfunction

        assign op_a = fwd_mux(i_fwd_a, i_id_ex.rs1_data, i_from_mem, i_from_wb);
        assign op_b = fwd_mux(i_fwd_b, i_id_ex.rs2_data, i_from_mem, i_from_wb);

        // Stores write the forwarded rs2
        assign o_store_data = op_b;
        assign alu_b        = i_id_ex.ctrl.alu_src_imm ? i_id_ex.imm : op_b;

        //////////////////////////////
        // ALU
        //////////////////////////////

        always_comb begin
                case (i_id_ex.ctrl.alu_op)
                ALU_SUB: o_alu_result = op_a - alu_b;
                ALU_AND: o_alu_result = op_a & alu_b;
                ALU_OR:  o_alu_result = op_a | alu_b;
                ALU_XOR: o_alu_result = op_a ^ alu_b;
                ALU_SLT: o_alu_result = word_t'($signed(op_a) < $signed(alu_b));
                default: o_alu_result = op_a + alu_b;
                endcase
        end

        //////////////////////////////
        // Branch
        //////////////////////////////

        // BNE inverts the compare
        assign equal      = (op_a == op_b);
        assign o_redirect = i_id_ex.ctrl.branch && (equal ^ i_id_ex.ctrl.branch_ne);
        assign o_target   = i_id_ex.pc + i_id_ex.imm[IMEM_AW+1:0];

endmodule

//--- hw/rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch (
        input  logic               clk,
        input  logic               i_rst_n,
        input  rv_pkg::imem_load_t i_load,
        input  logic               i_start,
        input  logic               i_stall,
        input  logic               i_redirect,
        input  rv_pkg::pc_t        i_target,
        input  logic               i_halt_seen,
        output rv_pkg::instr_t     o_instr,
        output rv_pkg::pc_t        o_pc,
        output logic               o_valid
);
        import rv_pkg::*;

        instr_t imem [2**IMEM_AW];
        pc_t    pc;
        logic   running;
        instr_t fetched;
        logic   fetch_en;

        // Word index from byte PC
        assign fetched  = imem[pc[IMEM_AW+1:2]];
        assign fetch_en = running && !i_halt_seen && !i_stall;

        // Program load port, idle core only
        always_ff @(posedge clk) begin
                if (i_load.valid && !running) begin
                        imem[i_load.addr] <= i_load.instr;
                end
        end

        always_ff @(posedge clk) begin
                if (!i_rst_n) begin
                        pc      <= '0;
                        running <= 1'b0;
                        o_valid <= 1'b0;
                end else if (i_start) begin
                        pc      <= '0;
                        running <= 1'b1;
                        o_valid <= 1'b0;
                end else if (i_redirect) begin
                        // Taken branch squashes IF/ID
                        // An ECALL in the branch shadow is squashed too, so fetch resumes
                        pc      <= i_target;
                        running <= 1'b1;
                        o_valid <= 1'b0;
                end else if (fetch_en) begin
                        pc      <= pc + pc_t'(4);
                        o_valid <= 1'b1;
                        // Stop after ECALL
                        if (fetched[6:0] == OPC_SYSTEM) begin
                                running <= 1'b0;
                        end
                end else if (!i_stall) begin
                        o_valid <= 1'b0;
                end
        end

        // IF/ID payload
        always_ff @(posedge clk) begin
                if (fetch_en && !i_start && !i_redirect) begin
                        o_instr <= fetched;
                        o_pc    <= pc;
                end
        end

        a_no_load_while_running: assert property (
                @(posedge clk) disable iff (!i_rst_n) i_load.valid |-> !running)
                else $error("instruction load during a run");

endmodule

//--- hw/rv_pkg.sv
package rv_pkg;

        //////////////////////////////
        // Widths
        //////////////////////////////

        localparam int XLEN    = 32;
        localparam int IMEM_AW = 6;
        localparam int DMEM_AW = 6;

        typedef logic [XLEN-1:0]    word_t;
        typedef logic [31:0]        instr_t;
        // Byte address into instruction memory
        typedef logic [IMEM_AW+1:0] pc_t;
        typedef logic [4:0]         reg_id_t;

        //////////////////////////////
        // Opcodes
        //////////////////////////////

        localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
        localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
        localparam logic [6:0] OPC_LOAD   = 7'b0000011;
        localparam logic [6:0] OPC_STORE  = 7'b0100011;
        localparam logic [6:0] OPC_BRANCH = 7'b1100011;
        localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

        // Operand source for the execute stage
        typedef enum logic [1:0] {
                FWD_NONE,
                FWD_MEM,
                FWD_WB
        } fwd_sel_e;

        typedef enum logic [2:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_XOR,
                ALU_SLT
        } alu_op_e;

        //////////////////////////////
        // Stage records
        //////////////////////////////

        // One-word program load strobe
        typedef struct packed {
                logic               valid;
                logic [IMEM_AW-1:0] addr;
                instr_t             instr;
        } imem_load_t;

        // All zero is a bubble
        typedef struct packed {
                logic    reg_write;
                logic    mem_write;
                logic    mem_to_reg;
                logic    alu_src_imm;
                logic    branch;
                logic    branch_ne;
                logic    halt;
                alu_op_e alu_op;
        } ctrl_t;

        typedef struct packed {
                pc_t     pc;
                reg_id_t rs1;
                reg_id_t rs2;
                reg_id_t rd;
                word_t   rs1_data;
                word_t   rs2_data;
                word_t   imm;
                ctrl_t   ctrl;
        } id_ex_t;

        typedef struct packed {
                word_t   alu_result;
                word_t   store_data;
                reg_id_t rd;
                logic    reg_write;
                logic    mem_write;
                logic    mem_to_reg;
                logic    halt;
        } ex_mem_t;

        typedef struct packed {
                word_t   result;
                reg_id_t rd;
                logic    reg_write;
                logic    halt;
        } mem_wb_t;

        // Retirement trace
        typedef struct packed {
                logic    valid;
                reg_id_t rd;
                word_t   data;
        } wb_trace_t;

endpackage

//--- hw/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
        input  logic            clk,
        input  logic            i_rst_n,
        input  logic            i_we,
        input  rv_pkg::reg_id_t i_wr_id,
        input  rv_pkg::reg_id_t i_rd1_id,
        input  rv_pkg::reg_id_t i_rd2_id,
        input  rv_pkg::word_t   i_wr_data,
        output rv_pkg::word_t   o_rd1,
        output rv_pkg::word_t   o_rd2
);
        import rv_pkg::*;

        // x0 has no storage
        word_t regs [1:31];

        always_ff @(posedge clk) begin
                if (!i_rst_n) begin
                        for (int i = 1; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (i_we && i_wr_id != '0) begin
                        regs[i_wr_id] <= i_wr_data;
                end
        end

        // Same-cycle write goes straight to the read ports
        assign o_rd1 = (i_rd1_id == '0) ? '0 :
                       (i_we && i_wr_id == i_rd1_id) ? i_wr_data : regs[i_rd1_id];
        assign o_rd2 = (i_rd2_id == '0) ? '0 :
                       (i_we && i_wr_id == i_rd2_id) ? i_wr_data : regs[i_rd2_id];

        // Writes to x0 are masked off before ID/EX
        a_no_x0_write: assert property (
                @(posedge clk) disable iff (!i_rst_n) i_we |-> i_wr_id != '0)
                else $error("register write to x0");

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
        output logic o_clk
);
        // 4 ns period, starts low
        initial begin
                o_clk = 1'b0;
                forever begin
                        #2 o_clk = ~o_clk;
                end
        end

endmodule

//--- testbench/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;
        import rv_pkg::*;

        // Watchdog budget
        localparam int NUM_TESTS     = 5;
        localparam int MAX_PROG      = 16;
        localparam int CYC_PER_INSTR = 8;
        localparam int CLK_NS        = 4;

        logic       clk;
        logic       rst_n;
        imem_load_t load;
        logic       start;
        wb_trace_t  wb;
        logic       halt;
        logic       before_start;

        // Program image and reference register model
        instr_t     prog [64];
        int         prog_len;
        word_t      rf [32];
        // Expected retirements, in program order across all tests
        reg_id_t    exp_rd [64];
        word_t      exp_data [64];
        int         exp_cnt = 0;
        int         seen = 0;
        reg_id_t    want_rd;
        word_t      want_data;
        logic       want_any;
        int         errors = 0;
        int         err_base;
        int         tests_run = 0;
        int         passed = 0;
        int         failed = 0;
        integer     seed = 9;
        logic [11:0] r;

        tb_clock u_clock (.o_clk(clk));

        rv_core u_rv_core (
                .clk    (clk),
                .i_rst_n(rst_n),
                .i_load (load),
                .i_start(start),
                .o_wb   (wb),
                .o_halt (halt)
        );

        //////////////////////////////
        // Writeback scoreboard
        //////////////////////////////

        assign want_any  = (seen < exp_cnt);
        assign want_rd   = exp_rd[seen];
        assign want_data = exp_data[seen];

        // Consume one entry per strobe
        always @(posedge clk) begin
                if (rst_n && wb.valid && want_any) begin
                        seen <= seen + 1;
                end
        end

        a_wb_rd: assert property (@(posedge clk) disable iff (!rst_n)
                wb.valid && want_any |-> wb.rd == want_rd)
                else begin
                        $display("ERR t=%0t o_wb.rd got %0d expected %0d",
                                 $time, $sampled(wb.rd), $sampled(want_rd));
                        errors++;
                end

        a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
                wb.valid && want_any |-> wb.data == want_data)
                else begin
                        $display("ERR t=%0t o_wb.data got %h expected %h",
                                 $time, $sampled(wb.data), $sampled(want_data));
                        errors++;
                end

        a_no_extra_wb: assert property (@(posedge clk) disable iff (!rst_n)
                wb.valid |-> want_any)
                else begin
                        $display("t=%0t writeback to x%0d when none was expected",
                                 $time, $sampled(wb.rd));
                        errors++;
                end

        // Halt holds until restarted, nothing retires behind it
        a_halt_holds: assert property (@(posedge clk) disable iff (!rst_n)
                halt && !start |=> halt)
                else begin
                        $display("t=%0t halt dropped without a start", $time);
                        errors++;
                end

        a_quiet_halt: assert property (@(posedge clk) disable iff (!rst_n)
                halt |-> !wb.valid)
                else begin
                        $display("t=%0t writeback seen while halted", $time);
                        errors++;
                end

        a_idle_reset: assert property (@(posedge clk) disable iff (!rst_n)
                before_start |-> !wb.valid && !halt)
                else begin
                        $display("t=%0t core active before the first start", $time);
                        errors++;
                end

        //////////////////////////////
        // Encoders and program build
        //////////////////////////////

        function automatic instr_t rtype_word(logic [6:0] f7, reg_id_t rs2, reg_id_t rs1,
                                              logic [2:0] f3, reg_id_t rd);
                return {f7, rs2, rs1, f3, rd, OPC_RTYPE};
        endfunction

        function automatic instr_t addi_word(reg_id_t rd, reg_id_t rs1, logic [11:0] imm);
                return {imm, rs1, 3'b000, rd, OPC_ITYPE};
        endfunction

        function automatic instr_t lw_word(reg_id_t rd, reg_id_t rs1, logic [11:0] imm);
                return {imm, rs1, 3'b010, rd, OPC_LOAD};
        endfunction

        function automatic instr_t sw_word(reg_id_t rs2, reg_id_t rs1, logic [11:0] imm);
                return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
        endfunction

        // BEQ is funct3 0, BNE is 1
        function automatic instr_t branch_word(logic ne, reg_id_t rs1, reg_id_t rs2,
                                               logic [12:0] off);
                return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11],
                        OPC_BRANCH};
        endfunction

        task automatic push_instr(instr_t instr);
                prog[prog_len] = instr;
                prog_len++;
        endtask

        // x0 writes leave no trace
        task automatic expect_wb(reg_id_t rd, word_t data);
                if (rd != '0) begin
                        exp_rd[exp_cnt]   = rd;
                        exp_data[exp_cnt] = data;
                        exp_cnt++;
                        rf[rd] = data;
                end
        endtask

        task automatic add_imm(reg_id_t rd, reg_id_t rs1, logic [11:0] imm);
                push_instr(addi_word(rd, rs1, imm));
                expect_wb(rd, rf[rs1] + {{20{imm[11]}}, imm});
        endtask

        // R-type op with its result from the ISA rules
        task automatic reg_reg_op(alu_op_e op, reg_id_t rd, reg_id_t rs1, reg_id_t rs2);
                word_t      a;
                word_t      b;
                word_t      res;
                logic [6:0] f7;
                logic [2:0] f3;
                a  = rf[rs1];
                b  = rf[rs2];
                f7 = 7'h00;
                case (op)
                ALU_SUB: begin
                        res = a - b;
                        f7  = 7'h20;
                        f3  = 3'b000;
                end
                ALU_AND: begin
                        res = a & b;
                        f3  = 3'b111;
                end
                ALU_OR: begin
                        res = a | b;
                        f3  = 3'b110;
                end
                ALU_XOR: begin
                        res = a ^ b;
                        f3  = 3'b100;
                end
                ALU_SLT: begin
                        res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        f3  = 3'b010;
                end
                default: begin
                        res = a + b;
                        f3  = 3'b000;
                end
                endcase
                push_instr(rtype_word(f7, rs2, rs1, f3, rd));
                expect_wb(rd, res);
        endtask

        //////////////////////////////
        // Run control
        //////////////////////////////

        task automatic begin_test();
                prog_len = 0;
                err_base = errors;
        endtask

        // One word per falling edge
        task automatic load_program();
                for (int i = 0; i < prog_len; i++) begin
                        @(negedge clk);
                        load = '{valid: 1'b1, addr: IMEM_AW'(i), instr: prog[i]};
                end
                @(negedge clk);
                load = '0;
        endtask

        task automatic start_core();
                @(negedge clk);
                start        = 1'b1;
                before_start = 1'b0;
                @(negedge clk);
                start = 1'b0;
        endtask

        task automatic run_test(string name, int hold_cycles);
                load_program();
                start_core();
                while (!halt) begin
                        @(negedge clk);
                end
                // Halt must outlast a few idle cycles
                repeat (hold_cycles) @(negedge clk);
                a_still_halted: assert (halt) else begin
                        $display("%s: halt flag fell after the program ended", name);
                        errors++;
                end
                a_all_retired: assert (seen == exp_cnt) else begin
                        $display("%s: %0d expected writebacks never appeared", name,
                                 exp_cnt - seen);
                        errors++;
                end
                tests_run++;
                if (errors == err_base) begin
                        passed++;
                        $display("test %0d %s: pass", tests_run, name);
                end else begin
                        failed++;
                        $display("test %0d %s: FAIL (%0d errors)", tests_run, name,
                                 errors - err_base);
                end
        endtask

        initial begin
                #(NUM_TESTS * MAX_PROG * CYC_PER_INSTR * CLK_NS + 50 * CLK_NS);
                $display("watchdog expired, a program never reached its halt");
                $display("Test failures found");
                $finish;
        end

        initial begin
                rst_n        = 1'b0;
                load         = '0;
                start        = 1'b0;
                before_start = 1'b1;
                for (int i = 0; i < 32; i++) begin
                        rf[i] = '0;
                end
                repeat (5) @(negedge clk);
                rst_n = 1'b1;
                // Idle window checked by a_idle_reset
                repeat (4) @(negedge clk);

                // Dependent chain, MEM and WB forwarding
                begin_test();
                r = 12'($random(seed));
                add_imm(1, 0, r);
                r = 12'($random(seed));
                add_imm(2, 0, r);
                reg_reg_op(ALU_ADD, 3, 1, 2);
                reg_reg_op(ALU_SUB, 4, 3, 1);
                reg_reg_op(ALU_AND, 5, 4, 3);
                reg_reg_op(ALU_OR, 6, 5, 2);
                reg_reg_op(ALU_XOR, 7, 6, 5);
                reg_reg_op(ALU_SLT, 8, 7, 1);
                r = 12'($random(seed));
                add_imm(9, 8, r);
                push_instr(32'h0000_0073);
                run_test("alu forwarding", 1);

                // Store, load, then load-use stall
                begin_test();
                add_imm(1, 0, 12'd40);
                r = 12'($random(seed));
                add_imm(2, 0, r);
                push_instr(sw_word(2, 1, 12'd8));
                push_instr(lw_word(3, 1, 12'd8));
                expect_wb(3, rf[2]);
                reg_reg_op(ALU_ADD, 4, 3, 2);
                push_instr(32'h0000_0073);
                run_test("load-use stall", 1);

                // BNE falls through, BEQ skips two
                begin_test();
                add_imm(1, 0, 12'd7);
                add_imm(2, 0, 12'd7);
                push_instr(branch_word(1'b1, 1, 2, 13'd12));
                add_imm(3, 0, 12'd1);
                push_instr(branch_word(1'b0, 1, 2, 13'd12));
                push_instr(addi_word(4, 0, 12'd99));
                push_instr(addi_word(5, 0, 12'd99));
                add_imm(6, 1, 12'd5);
                push_instr(32'h0000_0073);
                run_test("branches", 1);

                // Words after ECALL are never fetched
                begin_test();
                add_imm(1, 0, 12'd3);
                add_imm(2, 1, 12'd4);
                push_instr(32'h0000_0073);
                push_instr(addi_word(3, 0, 12'd1));
                push_instr(addi_word(4, 0, 12'd1));
                run_test("halt", 10);

                // Reload and rerun from PC 0, x0 stays zero
                begin_test();
                add_imm(0, 0, 12'd5);
                reg_reg_op(ALU_ADD, 5, 0, 0);
                add_imm(6, 0, 12'hfff);
                reg_reg_op(ALU_OR, 7, 6, 0);
                push_instr(32'h0000_0073);
                run_test("restart and x0", 1);

                $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                         tests_run, passed, failed, errors);
                if (errors == 0) begin
                        $display("All tests passed!");
                end else begin
                        $display("Test failures found");
                end
                $finish;
        end

endmodule

//--- verilog.f
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_data_mem.sv
hw/rv_core.sv
testbench/tb_clock.sv
testbench/tb_rv_core.sv
